// File: source/rv_pkg.sv
package rv_pkg;

  // datapath geometry
  localparam int XLEN       = 32;
  localparam int NUM_REGS   = 32;
  localparam int INSN_BYTES = 4;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [XLEN-1:0] addr_t;
  typedef logic [31:0]     insn_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [6:0]      opcode_t;
  typedef logic [2:0]      funct3_t;
  typedef logic [3:0]      alu_op_t;

  // major opcodes that the core executes
  localparam opcode_t OP_LUI     = 7'b0110111;
  localparam opcode_t OP_REG_IMM = 7'b0010011;
  localparam opcode_t OP_BRANCH  = 7'b1100011;
  localparam opcode_t OP_SYSTEM  = 7'b1110011;

  // funct3 for register-immediate operations
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101;
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  // funct3 for conditional branches
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // funct7 marking srai instead of srli
  localparam logic [6:0] F7_ALT = 7'b0100000;

  // ALU operation codes
  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SLT  = 4'd1;
  localparam alu_op_t ALU_SLTU = 4'd2;
  localparam alu_op_t ALU_XOR  = 4'd3;
  localparam alu_op_t ALU_OR   = 4'd4;
  localparam alu_op_t ALU_AND  = 4'd5;
  localparam alu_op_t ALU_SLL  = 4'd6;
  localparam alu_op_t ALU_SRL  = 4'd7;
  localparam alu_op_t ALU_SRA  = 4'd8;
  localparam alu_op_t ALU_LUI  = 4'd9;

  // ecall is the only system word that is recognised
  localparam insn_t ECALL_WORD = 32'h0000_0073;

endpackage

// File: source/reg_file.sv
module reg_file (
  input  logic             clk,
  input  logic             rst,
  input  logic             wr_en,
  input  rv_pkg::reg_idx_t wr_idx,
  input  rv_pkg::word_t    wr_data,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);
  import rv_pkg::*;

  // x0 has no storage
  word_t regs [1:NUM_REGS-1];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 1; i < NUM_REGS; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wr_en)
    begin
      regs[wr_idx] <= wr_data;
    end
  end

  // two independent combinational read ports
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  // the decoder is responsible for filtering writes to x0
  assert property (@(posedge clk) disable iff (rst) wr_en |-> wr_idx != '0)
    else $error("reg_file: write enabled for x0");

endmodule

// File: source/insn_decoder.sv
module insn_decoder (
  input  rv_pkg::insn_t    insn,
  output rv_pkg::reg_idx_t rs1,
  output rv_pkg::reg_idx_t rs2,
  output rv_pkg::reg_idx_t rd,
  output logic             wr_en,
  output rv_pkg::alu_op_t  alu_op,
  output rv_pkg::word_t    imm,
  output logic             is_branch,
  output rv_pkg::funct3_t  branch_f3,
  output rv_pkg::word_t    branch_imm,
  output logic             halt
);
  import rv_pkg::*;

  opcode_t    opcode;
  funct3_t    funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_u;
  word_t      imm_b;
  word_t      shamt;
  logic       writes_rd;

  // fixed field positions of the base encoding
  assign opcode = insn[6:0];
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign funct7 = insn[31:25];

  // sign-extended immediates
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};

  // shift amount sits in the low five bits of the I immediate
  assign shamt = {{(XLEN-5){1'b0}}, insn[24:20]};

  always_comb
  begin
    writes_rd = 1'b0;
    alu_op    = ALU_ADD;
    imm       = imm_i;
    is_branch = 1'b0;
    halt      = 1'b0;

    case (opcode)
      OP_LUI:
      begin
        writes_rd = 1'b1;
        alu_op    = ALU_LUI;
        imm       = imm_u;
      end
      OP_REG_IMM:
      begin
        writes_rd = 1'b1;
        case (funct3)
          F3_ADD:  alu_op = ALU_ADD;
          F3_SLT:  alu_op = ALU_SLT;
          F3_SLTU: alu_op = ALU_SLTU;
          F3_XOR:  alu_op = ALU_XOR;
          F3_OR:   alu_op = ALU_OR;
          F3_AND:  alu_op = ALU_AND;
          F3_SLL:
          begin
            alu_op    = ALU_SLL;
            imm       = shamt;
            writes_rd = (funct7 == '0);
          end
          F3_SR:
          begin
            imm = shamt;
            if (funct7 == F7_ALT)
            begin
              alu_op = ALU_SRA;
            end
            else
            begin
              alu_op    = ALU_SRL;
              writes_rd = (funct7 == '0);
            end
          end
        endcase
      end
      OP_BRANCH:
      begin
        case (funct3)
          F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU: is_branch = 1'b1;
          default: is_branch = 1'b0;
        endcase
      end
      OP_SYSTEM:
      begin
        // anything other than a plain ecall is a no-op
        halt = (insn == ECALL_WORD);
      end
      default:
      begin
        writes_rd = 1'b0;
      end
    endcase
  end

  // writes to x0 are dropped here
  assign wr_en = writes_rd && (rd != '0);

  assign branch_f3  = funct3;
  assign branch_imm = imm_b;

endmodule

// File: source/int_alu.sv
module int_alu (
  input  rv_pkg::alu_op_t alu_op,
  input  rv_pkg::word_t   operand,
  input  rv_pkg::word_t   imm,
  output rv_pkg::word_t   result
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = imm[4:0];
  assign lt_signed   = $signed(operand) < $signed(imm);
  assign lt_unsigned = operand < imm;

  always_comb
  begin
    case (alu_op)
      ALU_ADD:
      begin
        result = operand + imm;
      end
      ALU_SLT:
      begin
        result = {{(XLEN-1){1'b0}}, lt_signed};
      end
      ALU_SLTU:
      begin
        result = {{(XLEN-1){1'b0}}, lt_unsigned};
      end
      ALU_XOR:
      begin
        result = operand ^ imm;
      end
      ALU_OR:
      begin
        result = operand | imm;
      end
      ALU_AND:
      begin
        result = operand & imm;
      end
      ALU_SLL:
      begin
        result = operand << shamt;
      end
      ALU_SRL:
      begin
        result = operand >> shamt;
      end
      ALU_SRA:
      begin
        // sign bit fills in from the top
        result = word_t'($signed(operand) >>> shamt);
      end
      ALU_LUI:
      begin
        // upper immediate arrives already shifted
        result = imm;
      end
      default:
      begin
        result = '0;
      end
    endcase
  end

endmodule

// File: source/pc_unit.sv
module pc_unit (
  input  logic            clk,
  input  logic            rst,
  input  logic            is_branch,
  input  rv_pkg::funct3_t branch_f3,
  input  rv_pkg::word_t   branch_imm,
  input  rv_pkg::word_t   rs1_data,
  input  rv_pkg::word_t   rs2_data,
  input  logic            halt,
  output rv_pkg::addr_t   pc
);
  import rv_pkg::*;

  logic  taken;
  addr_t pc_seq;
  addr_t pc_next;

  // branch condition from the two register operands
  always_comb
  begin
    case (branch_f3)
      F3_BEQ:  taken = (rs1_data == rs2_data);
      F3_BNE:  taken = (rs1_data != rs2_data);
      F3_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
      F3_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      F3_BLTU: taken = (rs1_data < rs2_data);
      F3_BGEU: taken = (rs1_data >= rs2_data);
      default: taken = 1'b0;
    endcase
  end

  assign pc_seq = pc + addr_t'(INSN_BYTES);

  // halt freezes the pc on the current ecall
  always_comb
  begin
    if (halt)
      pc_next = pc;
    else if (is_branch && taken)
      pc_next = pc + branch_imm;
    else
      pc_next = pc_seq;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      pc <= '0;
    else
      pc <= pc_next;
  end

  // fetch stays word aligned
  assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc_unit: misaligned pc %h", pc);

endmodule

// File: source/rv_core.sv
module rv_core (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::insn_t    insn,
  output rv_pkg::addr_t    pc,
  output logic             halt,
  output logic             wb_en,
  output rv_pkg::reg_idx_t wb_rd,
  output rv_pkg::word_t    wb_data
);
  import rv_pkg::*;

  // decode outputs
  reg_idx_t rs1;
  reg_idx_t rs2;
  logic     dec_wr_en;
  alu_op_t  alu_op;
  word_t    imm;
  logic     is_branch;
  funct3_t  branch_f3;
  word_t    branch_imm;

  // register operands
  word_t rs1_data;
  word_t rs2_data;

  // write-back goes to the ports and the register file together
  insn_decoder u_decoder (
    .insn       (insn),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (wb_rd),
    .wr_en      (dec_wr_en),
    .alu_op     (alu_op),
    .imm        (imm),
    .is_branch  (is_branch),
    .branch_f3  (branch_f3),
    .branch_imm (branch_imm),
    .halt       (halt)
  );

  // no write-back is reported while reset is held
  assign wb_en = dec_wr_en && !rst;

  reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .wr_en    (wb_en),
    .wr_idx   (wb_rd),
    .wr_data  (wb_data),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  int_alu u_alu (
    .alu_op  (alu_op),
    .operand (rs1_data),
    .imm     (imm),
    .result  (wb_data)
  );

  pc_unit u_pc_unit (
    .clk        (clk),
    .rst        (rst),
    .is_branch  (is_branch),
    .branch_f3  (branch_f3),
    .branch_imm (branch_imm),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .halt       (halt),
    .pc         (pc)
  );

endmodule

// File: verification/tb_rv_core.sv
module tb_rv_core;
  import rv_pkg::*;

  localparam int MEM_WORDS      = 64;
  localparam int SEED           = 77;
  localparam int RESET_CYCLES   = 4;
  localparam int RUN_CYCLES     = 1000;
  localparam int HALT_CYCLES    = 10;
  localparam int RESUME_CYCLES  = 10;
  localparam int TIMEOUT_CYCLES = 1040;

  // what each memory word holds is kept beside the encoded word
  localparam int KIND_LUI    = 0;
  localparam int KIND_IMM    = 1;
  localparam int KIND_BRANCH = 2;

  logic     clk;
  logic     rst;
  logic     force_ecall;
  insn_t    insn;
  addr_t    pc;
  logic     halt;
  logic     wb_en;
  reg_idx_t wb_rd;
  word_t    wb_data;

  insn_t    imem      [MEM_WORDS];
  int       slot_kind [MEM_WORDS];
  int       slot_op   [MEM_WORDS];
  reg_idx_t slot_rd   [MEM_WORDS];
  reg_idx_t slot_rs1  [MEM_WORDS];
  reg_idx_t slot_rs2  [MEM_WORDS];
  word_t    slot_imm  [MEM_WORDS];

  word_t model_regs [NUM_REGS];
  addr_t model_pc;
  int    cycle_count = 0;

  rv_core UUT (
    .clk     (clk),
    .rst     (rst),
    .insn    (insn),
    .pc      (pc),
    .halt    (halt),
    .wb_en   (wb_en),
    .wb_rd   (wb_rd),
    .wb_data (wb_data)
  );

  // combinational fetch where a forced ecall overrides the program
  assign insn = force_ecall ? ECALL_WORD : imem[pc[7:2]];

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "stopping at first failure");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      $display("ERR %s got %h expected %h at pc %h", name, got, exp, model_pc);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp)
    begin
      $display("ERR %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp)
    begin
      $display("ERR %s got %h expected %h at pc %h", name, got, exp, model_pc);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("ERR %s got %h expected %h at pc %h", name, got, exp, model_pc);
      abort_run();
    end
  endtask

  function automatic funct3_t imm_funct3(input int op);
    case (op)
      0: return F3_ADD;
      1: return F3_SLT;
      2: return F3_SLTU;
      3: return F3_XOR;
      4: return F3_OR;
      5: return F3_AND;
      6: return F3_SLL;
      default: return F3_SR;
    endcase
  endfunction

  function automatic funct3_t branch_funct3(input int op);
    case (op)
      0: return F3_BEQ;
      1: return F3_BNE;
      2: return F3_BLT;
      3: return F3_BGE;
      4: return F3_BLTU;
      default: return F3_BGEU;
    endcase
  endfunction

  // signed order is unsigned order with the sign bits flipped
  function automatic logic signed_less(input word_t a, input word_t b);
    return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
  endfunction

  function automatic word_t imm_result(input int op, input word_t a, input word_t imm);
    word_t r;
    case (op)
      0: r = a + imm;
      1: r = {31'b0, signed_less(a, imm)};
      2: r = {31'b0, a < imm};
      3: r = a ^ imm;
      4: r = a | imm;
      5: r = a & imm;
      6: r = a << imm[4:0];
      7: r = a >> imm[4:0];
      default:
      begin
        // shift one bit at a time and copy the sign in
        r = a;
        for (int k = 0; k < int'(imm[4:0]); k++)
        begin
          r = {r[31], r[31:1]};
        end
      end
    endcase
    return r;
  endfunction

  function automatic logic branch_taken(input int op, input word_t a, input word_t b);
    case (op)
      0: return a == b;
      1: return a != b;
      2: return signed_less(a, b);
      3: return !signed_less(a, b);
      4: return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic fill_program();
    int          pick;
    int          op;
    int          off_words;
    word_t       rnd;
    word_t       off_w;
    logic [11:0] imm12;
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      pick = int'($urandom_range(0, 9));
      op = 0;
      rnd = $urandom;
      // few registers so that equal operands show up
      slot_rd[i]  = reg_idx_t'($urandom_range(0, 7));
      slot_rs1[i] = reg_idx_t'($urandom_range(0, 7));
      slot_rs2[i] = reg_idx_t'($urandom_range(0, 7));
      if (pick < 2)
      begin
        slot_kind[i] = KIND_LUI;
        slot_imm[i]  = {rnd[31:12], 12'b0};
        imem[i]      = {rnd[31:12], slot_rd[i], OP_LUI};
      end
      else if (pick < 7)
      begin
        op = int'($urandom_range(0, 8));
        if (op >= 6)
          imm12 = {(op == 8) ? F7_ALT : 7'b0, rnd[4:0]};
        else if (rnd[31])
          imm12 = {{8{rnd[3]}}, rnd[3:0]};
        else
          imm12 = rnd[11:0];
        slot_kind[i] = KIND_IMM;
        slot_imm[i]  = {{20{imm12[11]}}, imm12};
        imem[i]      = {imm12, slot_rs1[i], imm_funct3(op), slot_rd[i], OP_REG_IMM};
      end
      else
      begin
        op = int'($urandom_range(0, 5));
        // offset zero is skipped since a taken self loop would stall the run
        off_words = int'($urandom_range(0, 30)) - 15;
        if (off_words >= 0)
          off_words++;
        off_w = word_t'(off_words * 4);
        slot_kind[i] = KIND_BRANCH;
        slot_imm[i]  = off_w;
        imem[i]      = {off_w[12], off_w[10:5], slot_rs2[i], slot_rs1[i], branch_funct3(op),
                        off_w[4:1], off_w[11], OP_BRANCH};
      end
      slot_op[i] = op;
    end
  endtask

  // compare the settled outputs and then step the model
  task automatic check_cycle();
    int    s;
    word_t exp_data;
    logic  exp_wr;
    addr_t next_pc;
    s = int'(model_pc[7:2]);
    next_pc = model_pc + addr_t'(INSN_BYTES);
    check_addr("pc", pc, model_pc);
    check_bit("halt", halt, force_ecall);
    if (force_ecall)
    begin
      check_bit("wb_en", wb_en, 1'b0);
      next_pc = model_pc;
    end
    else if (slot_kind[s] == KIND_BRANCH)
    begin
      check_bit("wb_en", wb_en, 1'b0);
      if (branch_taken(slot_op[s], model_regs[slot_rs1[s]], model_regs[slot_rs2[s]]))
        next_pc = model_pc + slot_imm[s];
    end
    else
    begin
      if (slot_kind[s] == KIND_LUI)
        exp_data = slot_imm[s];
      else
        exp_data = imm_result(slot_op[s], model_regs[slot_rs1[s]], slot_imm[s]);
      exp_wr = (slot_rd[s] != '0);
      check_bit("wb_en", wb_en, exp_wr);
      if (exp_wr)
      begin
        check_idx("wb_rd", wb_rd, slot_rd[s]);
        check_word("wb_data", wb_data, exp_data);
        model_regs[slot_rd[s]] = exp_data;
      end
    end
    model_pc = next_pc;
  endtask

  task automatic run_cycle();
    @(negedge clk);
    check_cycle();
    @(posedge clk);
  endtask

  // reset holds pc at zero and reports no write-back
  task automatic check_during_reset();
    @(posedge clk);
    repeat (RESET_CYCLES - 1)
    begin
      @(negedge clk);
      check_addr("pc", pc, addr_t'(0));
      check_bit("wb_en", wb_en, 1'b0);
      @(posedge clk);
    end
  endtask

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  initial
  begin
    rst         <= 1'b1;
    force_ecall <= 1'b0;
    void'($urandom(SEED));
    fill_program();
    for (int i = 0; i < NUM_REGS; i++)
    begin
      model_regs[i] = '0;
    end
    model_pc = '0;
    check_during_reset();
    rst <= 1'b0;
    repeat (RUN_CYCLES) run_cycle();
    // hold the core on an ecall and then let it go
    force_ecall <= 1'b1;
    repeat (HALT_CYCLES) run_cycle();
    force_ecall <= 1'b0;
    repeat (RESUME_CYCLES) run_cycle();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: build.f
source/rv_pkg.sv
source/reg_file.sv
source/insn_decoder.sv
source/int_alu.sv
source/pc_unit.sv
source/rv_core.sv
verification/tb_rv_core.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the rv_core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rv_core -f build.f
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_rv_core 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TESTS PASSED"; then
  exit 0
fi
exit 1
